/* sensor_pkg.sv */
package sensor_pkg;

    // ************************************************************
    // pixel and display geometry
    // ************************************************************
    localparam int PIXEL_BITS      = 8;    // raw sensor pixel
    localparam int PIXELS_PER_WORD = 4;    // pixels packed per input word
    localparam int FIELD_BITS      = 10;   // display field, pixel in top 8
    localparam int FIELD_COPIES    = 3;    // one field per color slot

    localparam int PIXEL_WORD_W   = PIXEL_BITS * PIXELS_PER_WORD;                // 32
    localparam int DISPLAY_WORD_W = PIXELS_PER_WORD * FIELD_COPIES * FIELD_BITS; // 120

    // link side
    localparam int LINK_WORD_W = 128;
    localparam int LANE_W      = 32;

    typedef logic [PIXEL_WORD_W-1:0]   pixel_word_t;
    typedef logic [DISPLAY_WORD_W-1:0] display_word_t;
    typedef logic [LINK_WORD_W-1:0]    link_word_t;
    typedef logic [LANE_W-1:0]         lane_word_t;

    // payload of the expander output slice, 122 bits
    typedef struct packed {
        display_word_t data;
        logic          user;   // start of frame
        logic          last;   // end of line
    } display_beat_t;

    // payload of the serializer output slice, 33 bits
    typedef struct packed {
        lane_word_t data;
        logic       last;      // fourth beat of a link word
    } lane_beat_t;

    // ************************************************************
    // bring-up defaults, board values at 20 MHz
    // ************************************************************
    localparam int DEF_EN_CYCLES        = 20;     // 1 us
    localparam int DEF_PIXEL_RST_CYCLES = 2000;   // 100 us
    localparam int DEF_PATH_RST_CYCLES  = 20000;  // 1 ms
    localparam int DEF_HEARTBEAT_BIT    = 23;     // ~0.4 s half period

    localparam int SEQ_CNT_W = 26;   // bring-up counter, saturating

endpackage

/* sensor_bringup_ctrl.sv */
module sensor_bringup_ctrl #(
    parameter int EN_CYCLES        = sensor_pkg::DEF_EN_CYCLES,
    parameter int PIXEL_RST_CYCLES = sensor_pkg::DEF_PIXEL_RST_CYCLES,
    parameter int PATH_RST_CYCLES  = sensor_pkg::DEF_PATH_RST_CYCLES,
    parameter int HEARTBEAT_BIT    = sensor_pkg::DEF_HEARTBEAT_BIT
) (
    input  logic clk20m,
    input  logic peripheral_aresetn,
    input  logic channel_up,        // serial link status
    output logic pdlu_en,           // sensor power enable
    output logic pdlu_rstn,         // sensor core reset
    output logic pdlu_pixel_rstn,   // sensor pixel array reset
    output logic path_rstn,         // internal pixel/link datapath reset
    output logic led,               // heartbeat
    output logic link_error         // sticky link-loss flag
);
    import sensor_pkg::*;

    // thresholds at counter width
    localparam logic [SEQ_CNT_W-1:0] EN_THR        = SEQ_CNT_W'(EN_CYCLES);
    localparam logic [SEQ_CNT_W-1:0] PIXEL_RST_THR = SEQ_CNT_W'(PIXEL_RST_CYCLES);
    localparam logic [SEQ_CNT_W-1:0] PATH_RST_THR  = SEQ_CNT_W'(PATH_RST_CYCLES);

    logic [SEQ_CNT_W-1:0]   seq_cnt;     // bring-up timebase
    logic [1:0]             rst_sync;    // reset release synchronizer
    logic [HEARTBEAT_BIT:0] hb_cnt;      // free running
    logic                   link_armed;  // channel seen up once
    logic [1:0]             up_hist;     // [1] older, [0] newer

    // ************************************************************
    // reset synchronizer
    // ************************************************************
    // async assert, release two edges later
    always_ff @(posedge clk20m or negedge peripheral_aresetn) begin
        if (!peripheral_aresetn) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    // ************************************************************
    // bring-up sequencing
    // ************************************************************
    // counter reads 0 at the first edge after release, then counts up
    always_ff @(posedge clk20m or negedge peripheral_aresetn) begin
        if (!peripheral_aresetn) begin
            seq_cnt <= '0;
        end else if (seq_cnt != '1) begin
            seq_cnt <= seq_cnt + 1'b1;
        end                                  // else hold at all ones
    end

    // registered compares, each control lags the threshold by one edge
    always_ff @(posedge clk20m or negedge peripheral_aresetn) begin
        if (!peripheral_aresetn) begin
            pdlu_en         <= 1'b0;
            pdlu_rstn       <= 1'b0;
            pdlu_pixel_rstn <= 1'b0;
            path_rstn       <= 1'b0;
        end else begin
            pdlu_en         <= (seq_cnt >= EN_THR);         // power first
            pdlu_rstn       <= (seq_cnt >= EN_THR);         // core out of reset with power
            pdlu_pixel_rstn <= (seq_cnt >= PIXEL_RST_THR);  // then the array
            // datapath last, and only once the synchronized reset is out
            path_rstn       <= rst_sync[1] && (seq_cnt >= PATH_RST_THR);
        end
    end

    // ************************************************************
    // heartbeat
    // ************************************************************
    always_ff @(posedge clk20m or negedge peripheral_aresetn) begin
        if (!peripheral_aresetn) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign led = hb_cnt[HEARTBEAT_BIT];   // half period 2**HEARTBEAT_BIT

    // ************************************************************
    // link-loss monitor
    // ************************************************************
    // only a fall after the link was up counts as a loss
    always_ff @(posedge clk20m or negedge peripheral_aresetn) begin
        if (!peripheral_aresetn) begin
            link_armed <= 1'b0;
            up_hist    <= 2'b00;
            link_error <= 1'b0;
        end else begin
            if (channel_up) begin
                link_armed <= 1'b1;
            end
            if (link_armed) begin
                up_hist <= {up_hist[0], channel_up};
            end
            // high then low in history = falling edge
            if (up_hist == 2'b10) begin
                link_error <= 1'b1;   // sticky until reset
            end
        end
    end

endmodule

/* stream_slice.sv */
module stream_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk20m,
    input  logic     rstn,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_data;    // output register
    payload_t spare_data;   // skid entry, filled when main stalls
    logic     main_valid;
    logic     spare_valid;
    logic     main_valid_d;
    logic     spare_valid_d;
    logic     main_load;
    logic     main_from_spare;
    logic     spare_load;
    logic     in_fire;
    logic     out_fire;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = main_valid && out_ready;

    // next occupancy; in_ready is low whenever spare is full
    always_comb begin
        main_valid_d    = main_valid;
        spare_valid_d   = spare_valid;
        main_load       = 1'b0;
        main_from_spare = 1'b0;
        spare_load      = 1'b0;
        if (!main_valid || out_fire) begin
            if (spare_valid) begin
                main_valid_d    = 1'b1;    // oldest item moves up
                spare_valid_d   = 1'b0;
                main_load       = 1'b1;
                main_from_spare = 1'b1;
            end else begin
                main_valid_d = in_fire;    // straight into main
                main_load    = in_fire;
            end
        end else if (in_fire) begin
            spare_valid_d = 1'b1;          // main stalled, park it
            spare_load    = 1'b1;
        end
    end

    always_ff @(posedge clk20m or negedge rstn) begin
        if (!rstn) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            main_valid  <= main_valid_d;
            spare_valid <= spare_valid_d;
            in_ready    <= !spare_valid_d;   // registered, room for one more
        end
    end

    // payload registers
    always_ff @(posedge clk20m) begin
        if (main_load) begin
            main_data <= main_from_spare ? spare_data : in_data;
        end
        if (spare_load) begin
            spare_data <= in_data;
        end
    end

    assign out_data  = main_data;
    assign out_valid = main_valid;

endmodule

/* pixel_expander.sv */
module pixel_expander (
    input  logic                      clk20m,
    input  logic                      path_rstn,
    input  sensor_pkg::pixel_word_t   pix_data,
    input  logic                      pix_user,    // start of frame
    input  logic                      pix_last,    // end of line
    input  logic                      pix_valid,
    output logic                      pix_ready,
    output sensor_pkg::display_word_t disp_data,
    output logic                      disp_user,
    output logic                      disp_last,
    output logic                      disp_valid,
    input  logic                      disp_ready
);
    import sensor_pkg::*;

    localparam int PAD_BITS = FIELD_BITS - PIXEL_BITS;   // zero lsbs per field

    display_word_t disp_word;
    display_beat_t beat_in;
    display_beat_t beat_out;

    // pixel p owns fields 3p..3p+2, highest pixel in the highest bits
    always_comb begin
        disp_word = '0;
        for (int p = 0; p < PIXELS_PER_WORD; p++) begin
            for (int c = 0; c < FIELD_COPIES; c++) begin
                disp_word[(p*FIELD_COPIES + c)*FIELD_BITS +: FIELD_BITS] =
                    {pix_data[p*PIXEL_BITS +: PIXEL_BITS], {PAD_BITS{1'b0}}};
            end
        end
    end

    assign beat_in = '{data: disp_word, user: pix_user, last: pix_last};

    // one cycle to disp_valid, full rate
    stream_slice #(
        .payload_t (display_beat_t)
    ) u_disp_slice (
        .clk20m    (clk20m),
        .rstn      (path_rstn),
        .in_data   (beat_in),
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .out_data  (beat_out),
        .out_valid (disp_valid),
        .out_ready (disp_ready)
    );

    assign disp_data = beat_out.data;
    assign disp_user = beat_out.user;
    assign disp_last = beat_out.last;

endmodule

/* lane_serializer.sv */
module lane_serializer (
    input  logic                   clk20m,
    input  logic                   path_rstn,
    input  sensor_pkg::link_word_t link_word,
    input  logic                   link_valid,
    output logic                   link_ready,
    output sensor_pkg::lane_word_t lane_data,
    output logic                   lane_last,
    output logic                   lane_valid,
    input  logic                   lane_ready
);
    import sensor_pkg::*;

    localparam int BEATS      = LINK_WORD_W / LANE_W;   // 4
    localparam int BEAT_IDX_W = $clog2(BEATS);

    link_word_t            word_q;       // word being split
    logic                  word_valid;
    logic [BEAT_IDX_W-1:0] beat_idx;     // next beat to issue
    logic                  last_beat;
    logic                  slice_ready;
    logic                  push;         // beat taken by the slice
    logic                  take;         // new link word accepted
    lane_beat_t            beat_in;
    lane_beat_t            beat_out;

    assign last_beat = (beat_idx == BEAT_IDX_W'(BEATS - 1));
    assign push      = word_valid && slice_ready;

    // empty, or about to hand the last beat over; slice_ready is low in reset
    assign link_ready = slice_ready && (!word_valid || last_beat);
    assign take       = link_valid && link_ready;

    // ************************************************************
    // word register and beat index
    // ************************************************************
    always_ff @(posedge clk20m or negedge path_rstn) begin
        if (!path_rstn) begin
            word_valid <= 1'b0;
            beat_idx   <= '0;
        end else begin
            if (push) begin
                beat_idx <= beat_idx + 1'b1;   // wraps to 0 after the last beat
            end
            if (take) begin
                word_valid <= 1'b1;            // may refill on the last beat
            end else if (push && last_beat) begin
                word_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk20m) begin
        if (take) begin
            word_q <= link_word;
        end
    end

    // lowest lane first
    assign beat_in = '{data: word_q[LANE_W*beat_idx +: LANE_W], last: last_beat};

    stream_slice #(
        .payload_t (lane_beat_t)
    ) u_lane_slice (
        .clk20m    (clk20m),
        .rstn      (path_rstn),
        .in_data   (beat_in),
        .in_valid  (word_valid),
        .in_ready  (slice_ready),
        .out_data  (beat_out),
        .out_valid (lane_valid),
        .out_ready (lane_ready)
    );

    assign lane_data = beat_out.data;
    assign lane_last = beat_out.last;

endmodule

/* sensor_top.sv */
module sensor_top #(
    parameter int EN_CYCLES        = sensor_pkg::DEF_EN_CYCLES,
    parameter int PIXEL_RST_CYCLES = sensor_pkg::DEF_PIXEL_RST_CYCLES,
    parameter int PATH_RST_CYCLES  = sensor_pkg::DEF_PATH_RST_CYCLES,
    parameter int HEARTBEAT_BIT    = sensor_pkg::DEF_HEARTBEAT_BIT
) (
    input  logic                      clk20m,
    input  logic                      peripheral_aresetn,
    input  logic                      channel_up,
    // sensor controls
    output logic                      pdlu_en,
    output logic                      pdlu_rstn,
    output logic                      pdlu_pixel_rstn,
    // status
    output logic                      led,
    output logic                      link_error,
    // pixel stream in
    input  sensor_pkg::pixel_word_t   pix_data,
    input  logic                      pix_user,
    input  logic                      pix_last,
    input  logic                      pix_valid,
    output logic                      pix_ready,
    // display stream out
    output sensor_pkg::display_word_t disp_data,
    output logic                      disp_user,
    output logic                      disp_last,
    output logic                      disp_valid,
    input  logic                      disp_ready,
    // link stream in
    input  sensor_pkg::link_word_t    link_word,
    input  logic                      link_valid,
    output logic                      link_ready,
    // lane stream out
    output sensor_pkg::lane_word_t    lane_data,
    output logic                      lane_last,
    output logic                      lane_valid,
    input  logic                      lane_ready
);

    logic path_rstn;   // staged datapath reset from the sequencer

    // ************************************************************
    // control
    // ************************************************************
    sensor_bringup_ctrl #(
        .EN_CYCLES        (EN_CYCLES),
        .PIXEL_RST_CYCLES (PIXEL_RST_CYCLES),
        .PATH_RST_CYCLES  (PATH_RST_CYCLES),
        .HEARTBEAT_BIT    (HEARTBEAT_BIT)
    ) u_ctrl (
        .clk20m             (clk20m),
        .peripheral_aresetn (peripheral_aresetn),
        .channel_up         (channel_up),
        .pdlu_en            (pdlu_en),
        .pdlu_rstn          (pdlu_rstn),
        .pdlu_pixel_rstn    (pdlu_pixel_rstn),
        .path_rstn          (path_rstn),
        .led                (led),
        .link_error         (link_error)
    );

    // ************************************************************
    // datapaths
    // ************************************************************
    pixel_expander u_expander (
        .clk20m     (clk20m),
        .path_rstn  (path_rstn),
        .pix_data   (pix_data),
        .pix_user   (pix_user),
        .pix_last   (pix_last),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .disp_data  (disp_data),
        .disp_user  (disp_user),
        .disp_last  (disp_last),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready)
    );

    lane_serializer u_serializer (
        .clk20m     (clk20m),
        .path_rstn  (path_rstn),
        .link_word  (link_word),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .lane_data  (lane_data),
        .lane_last  (lane_last),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

endmodule

/* tb_checker.sv */
module tb_checker #(
    parameter int EN_CYCLES        = 4,
    parameter int PIXEL_RST_CYCLES = 10,
    parameter int PATH_RST_CYCLES  = 16,
    parameter int HEARTBEAT_BIT    = 3
) (
    input  logic                      clk20m,
    input  logic                      peripheral_aresetn,
    input  logic                      channel_up,
    input  logic                      pdlu_en,
    input  logic                      pdlu_rstn,
    input  logic                      pdlu_pixel_rstn,
    input  logic                      led,
    input  logic                      link_error,
    input  sensor_pkg::pixel_word_t   pix_data,
    input  logic                      pix_user,
    input  logic                      pix_last,
    input  logic                      pix_valid,
    input  logic                      pix_ready,
    input  sensor_pkg::display_word_t disp_data,
    input  logic                      disp_user,
    input  logic                      disp_last,
    input  logic                      disp_valid,
    input  logic                      disp_ready,
    input  sensor_pkg::link_word_t    link_word,
    input  logic                      link_valid,
    input  logic                      link_ready,
    input  sensor_pkg::lane_word_t    lane_data,
    input  logic                      lane_last,
    input  logic                      lane_valid,
    input  logic                      lane_ready,
    output int                        err_cnt,
    output int                        check_cnt,
    output int                        pending     // expected beats not yet seen
);
    timeunit 1ns;
    timeprecision 100ps;
    import sensor_pkg::*;

    localparam int BEATS = LINK_WORD_W / LANE_W;   // lane beats per link word

    display_beat_t disp_q[$];       // expected display beats in arrival order
    lane_beat_t    lane_q[$];
    display_beat_t exp_disp;
    display_beat_t new_disp;
    lane_beat_t    exp_lane;
    lane_beat_t    new_lane;
    int errs      = 0;
    int checks    = 0;
    int n_pending = 0;
    int edge_cnt  = -1;             // rising edges since reset release
    int up_run    = 0;              // consecutive high samples of channel_up
    int fall_age  = 0;              // cycles since a settled link fell
    bit armed     = 1'b0;           // an earlier high run armed the monitor
    bit fall_seen = 1'b0;

    assign err_cnt   = errs;
    assign check_cnt = checks;
    assign pending   = n_pending;

    // each pixel becomes three {p,00} fields, built from the top pixel down
    function automatic display_word_t expand_ref(pixel_word_t pix);
        display_word_t   w;
        logic [FIELD_BITS-1:0] field;
        w = '0;
        for (int p = PIXELS_PER_WORD - 1; p >= 0; p--) begin
            field = {pix[p*PIXEL_BITS +: PIXEL_BITS], 2'b00};
            w = (w << (FIELD_COPIES * FIELD_BITS)) | display_word_t'({field, field, field});
        end
        return w;
    endfunction

    function automatic lane_word_t serialize_ref(link_word_t w, int idx);
        return lane_word_t'(w >> (LANE_W * idx));   // beat 0 = lowest lane
    endfunction

    task automatic expect_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("FAILED %s: expected %h, got %h at %0d ns", name, exp, got, $time);
        end
    endtask

    task automatic compare_word(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("FAILED %s: expected %h, got %h at %0d ns", name, exp, got, $time);
        end
    endtask

    // ************************************************************
    // sampled on the falling edge where inputs and outputs have settled
    // ************************************************************
    always @(negedge clk20m) begin
        if (!peripheral_aresetn) begin
            edge_cnt  = -1;
            up_run    = 0;
            armed     = 1'b0;
            fall_seen = 1'b0;
            disp_q.delete();                          // DUT drops its contents too
            lane_q.delete();
            expect_bit("pdlu_en", pdlu_en, 1'b0);
            expect_bit("pdlu_rstn", pdlu_rstn, 1'b0);
            expect_bit("pdlu_pixel_rstn", pdlu_pixel_rstn, 1'b0);
            expect_bit("led", led, 1'b0);
            expect_bit("link_error", link_error, 1'b0);
            expect_bit("pix_ready", pix_ready, 1'b0);
            expect_bit("link_ready", link_ready, 1'b0);
            expect_bit("disp_valid", disp_valid, 1'b0);
            expect_bit("lane_valid", lane_valid, 1'b0);
        end else begin
            edge_cnt++;
            // control rises on the edge after the counter hits its threshold
            expect_bit("pdlu_en", pdlu_en, edge_cnt > EN_CYCLES);
            expect_bit("pdlu_rstn", pdlu_rstn, edge_cnt > EN_CYCLES);
            expect_bit("pdlu_pixel_rstn", pdlu_pixel_rstn, edge_cnt > PIXEL_RST_CYCLES);
            expect_bit("led", led, ((edge_cnt >> HEARTBEAT_BIT) % 2) == 1);
            if (edge_cnt <= PATH_RST_CYCLES + 1) begin   // path still in reset
                expect_bit("pix_ready", pix_ready, 1'b0);
                expect_bit("link_ready", link_ready, 1'b0);
            end

            // link monitor model
            if (fall_seen) begin
                fall_age++;
            end
            if (up_run > 0 && !channel_up) begin
                // history held a high sample only past the arming cycle
                if ((up_run >= 2 || armed) && !fall_seen) begin
                    fall_seen = 1'b1;
                    fall_age  = 0;
                end
                armed = 1'b1;
            end
            up_run = channel_up ? up_run + 1 : 0;
            if (!fall_seen) begin
                expect_bit("link_error", link_error, 1'b0);
            end else if (fall_age >= 3) begin
                expect_bit("link_error", link_error, 1'b1);   // sticky
            end

            // ************************************************************
            // output transfers against the queues
            // ************************************************************
            if (disp_valid && disp_ready) begin
                if (disp_q.size() == 0) begin
                    errs++;
                    $display("display beat at %0d ns has no matching pixel word", $time);
                end else begin
                    exp_disp = disp_q.pop_front();
                    compare_word("disp_data", 128'(disp_data), 128'(exp_disp.data));
                    expect_bit("disp_user", disp_user, exp_disp.user);
                    expect_bit("disp_last", disp_last, exp_disp.last);
                end
            end
            if (lane_valid && lane_ready) begin
                if (lane_q.size() == 0) begin
                    errs++;
                    $display("lane beat at %0d ns has no matching link word", $time);
                end else begin
                    exp_lane = lane_q.pop_front();
                    compare_word("lane_data", 128'(lane_data), 128'(exp_lane.data));
                    expect_bit("lane_last", lane_last, exp_lane.last);
                end
            end

            // input transfers that happen at the coming edge
            if (pix_valid && pix_ready) begin
                new_disp.data = expand_ref(pix_data);
                new_disp.user = pix_user;
                new_disp.last = pix_last;
                disp_q.push_back(new_disp);
            end
            if (link_valid && link_ready) begin
                for (int b = 0; b < BEATS; b++) begin
                    new_lane.data = serialize_ref(link_word, b);
                    new_lane.last = (b == BEATS - 1);    // only the fourth beat
                    lane_q.push_back(new_lane);
                end
            end
        end
        n_pending = disp_q.size() + lane_q.size();
    end

endmodule

/* tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import sensor_pkg::*;

    localparam int TMO = 100;   // cycles allowed for one handshake wait

    logic          clk20m = 1'b0;
    logic          peripheral_aresetn;
    logic          channel_up;
    logic          pdlu_en;
    logic          pdlu_rstn;
    logic          pdlu_pixel_rstn;
    logic          led;
    logic          link_error;
    pixel_word_t   pix_data;
    logic          pix_user;
    logic          pix_last;
    logic          pix_valid;
    logic          pix_ready;
    display_word_t disp_data;
    logic          disp_user;
    logic          disp_last;
    logic          disp_valid;
    logic          disp_ready;
    link_word_t    link_word;
    logic          link_valid;
    logic          link_ready;
    lane_word_t    lane_data;
    logic          lane_last;
    logic          lane_valid;
    logic          lane_ready;
    int            err_cnt;
    int            check_cnt;
    int            pending;
    int            fails = 0;        // timeouts and leftovers
    int            errs_before = 0;
    int            src_wait;
    int            sink_wait;
    bit            src_done;
    logic [31:0]   rng_src = 32'hb03d_cdad;
    logic [31:0]   rng_sink;         // sink side runs its own sequence

    always #25 clk20m = ~clk20m;     // 20 MHz

    sensor_top #(
        .EN_CYCLES        (4),
        .PIXEL_RST_CYCLES (10),
        .PATH_RST_CYCLES  (16),
        .HEARTBEAT_BIT    (3)
    ) DUT (.*);

    tb_checker #(
        .EN_CYCLES        (4),
        .PIXEL_RST_CYCLES (10),
        .PATH_RST_CYCLES  (16),
        .HEARTBEAT_BIT    (3)
    ) u_checker (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task step();
        @(posedge clk20m);
        #2;                          // drive just after the edge
    endtask

    task idle(int n);
        repeat (n) step();
    endtask

    task apply_reset();
        peripheral_aresetn = 1'b0;
        idle(2);
        peripheral_aresetn = 1'b1;
    endtask

    task report_test(string name);
        if (err_cnt + fails == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, err_cnt + fails - errs_before);
        end
        errs_before = err_cnt + fails;
    endtask

    task wait_bringup();
        src_wait = 0;
        while (!(pix_ready && link_ready) && src_wait < TMO) begin
            step();
            src_wait++;
        end
        if (!(pix_ready && link_ready)) begin
            fails++;
            $display("timeout: datapath never became ready after reset");
        end
    endtask

    // ************************************************************
    // pixel stream with random gaps and random disp_ready
    // ************************************************************
    task stream_pixels(int n);
        src_done = 1'b0;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    rng_src = xorshift32(rng_src);
                    if (rng_src[31]) begin       // idle gap
                        pix_valid = 1'b0;
                        step();
                    end
                    pix_data  = rng_src;
                    pix_user  = (i % 16 == 0);   // frame start
                    pix_last  = (i % 4 == 3);    // short lines
                    pix_valid = 1'b1;
                    src_wait  = 0;
                    while (!pix_ready && src_wait < TMO) begin
                        step();
                        src_wait++;
                    end
                    if (!pix_ready) begin
                        fails++;
                        $display("timeout: pix_ready stayed low on word %0d", i);
                        break;
                    end
                    step();                      // transfer edge
                end
                pix_valid = 1'b0;
                src_done  = 1'b1;
            end
            begin
                sink_wait = 0;
                while (!(src_done && pending == 0) && sink_wait < 20 * n) begin
                    rng_sink   = xorshift32(rng_sink);
                    disp_ready = rng_sink[0] | rng_sink[1];   // 3 of 4 cycles
                    step();
                    sink_wait++;
                end
            end
        join
        if (pending != 0) begin
            fails++;
            $display("%0d expected display beat(s) never came out", pending);
        end
    endtask

    task send_link_words(int n);
        src_done = 1'b0;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    for (int b = 0; b < 4; b++) begin
                        rng_src = xorshift32(rng_src);
                        link_word[32*b +: 32] = rng_src;
                    end
                    link_valid = 1'b1;
                    src_wait   = 0;
                    while (!link_ready && src_wait < TMO) begin
                        step();
                        src_wait++;
                    end
                    if (!link_ready) begin
                        fails++;
                        $display("timeout: link_ready stayed low on word %0d", i);
                        break;
                    end
                    step();
                end
                link_valid = 1'b0;
                src_done   = 1'b1;
            end
            begin
                sink_wait = 0;
                while (!(src_done && pending == 0) && sink_wait < 80 * n) begin
                    rng_sink   = xorshift32(rng_sink);
                    lane_ready = rng_sink[0];        // half rate on average
                    step();
                    sink_wait++;
                end
            end
        join
        if (pending != 0) begin
            fails++;
            $display("%0d expected lane beat(s) never came out", pending);
        end
    endtask

    // ************************************************************
    // link monitor followed by a reset that clears the sticky flag
    // ************************************************************
    task exercise_link_monitor();
        channel_up = 1'b0;
        idle(4);
        channel_up = 1'b1;               // one-cycle pulse gone before the history fills
        step();
        channel_up = 1'b0;
        idle(6);                         // monitor armed yet no flag
        channel_up = 1'b1;
        idle(8);
        channel_up = 1'b0;               // link lost
        src_wait = 0;
        while (!link_error && src_wait < TMO) begin
            step();
            src_wait++;
        end
        if (!link_error) begin
            fails++;
            $display("timeout: link_error never rose after channel_up fell");
        end
        idle(2);
        channel_up = 1'b1;               // recovery keeps the flag
        idle(8);
        apply_reset();
        idle(6);
    endtask

    initial begin
        peripheral_aresetn = 1'b1;       // driven low at 5 ns for a clean edge
        channel_up = 1'b0;
        pix_data   = '0;
        pix_user   = 1'b0;
        pix_last   = 1'b0;
        pix_valid  = 1'b0;
        disp_ready = 1'b0;
        link_word  = '0;
        link_valid = 1'b0;
        lane_ready = 1'b0;
        rng_sink   = xorshift32(rng_src ^ 32'h9e37_79b9);
        #5;
        apply_reset();
        wait_bringup();
        report_test("bring-up order");
        idle(40);                        // led watched cycle by cycle
        report_test("heartbeat");
        stream_pixels(200);
        report_test("pixel expansion");
        send_link_words(60);
        report_test("lane serialization");
        exercise_link_monitor();
        report_test("link monitor");
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt + fails);
        if (err_cnt + fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
sensor_pkg.sv
sensor_bringup_ctrl.sv
stream_slice.sv
pixel_expander.sv
lane_serializer.sv
sensor_top.sv
tb_checker.sv
tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --timescale 1ns/100ps --top-module tb_top \
    -f compile.f -o tb_top_sim > sim.log 2>&1 &&
./obj_dir/tb_top_sim >> sim.log 2>&1
grep -q "^TESTBENCH PASSED$" sim.log && echo "run_sim: pass" ||
    { echo "run_sim: fail, see sim.log"; exit 1; }
